/* common/matrix_settings.svh */
`ifndef MATRIX_SETTINGS_SVH
`define MATRIX_SETTINGS_SVH

// Panel geometry, cut down to keep simulation short
`define PANEL_COLS 16
`define PANEL_ROWS 8

// Top and bottom halves scan together
`define SCAN_ROWS (`PANEL_ROWS / 2)

`define NUM_PLANES 6                                // Bit planes per frame
`define FB_DEPTH (`PANEL_COLS * `PANEL_ROWS)        // 128 pixel words

// Shifter FIFO depth, also the credits the fetch starts with
`define CREDIT_DEPTH 2

// Output enable cycles on plane 0, doubled per plane
`define OE_UNIT 4

`endif

/* common/matrix_pkg.sv */
`include "matrix_settings.svh"

package matrix_pkg;

    typedef enum logic [1:0] {
        NOP    = 2'd0,
        PIXEL  = 2'd1,
        CONFIG = 2'd2
    } cmd_op_e;

    // Address is row * PANEL_COLS + column
    typedef logic [$clog2(`FB_DEPTH)-1:0] fb_addr_t;
    typedef logic [$clog2(`SCAN_ROWS)-1:0] row_addr_t;

    typedef struct packed {
        logic [4:0] red;
        logic [5:0] green;
        logic [4:0] blue;
    } rgb565_t;

    typedef struct packed {
        cmd_op_e    opcode;
        logic [6:0] pad;
        fb_addr_t   addr;
        rgb565_t    pixel;
    } pixel_cmd_t;

    // rgb_enable bit 0 is red, bit 1 green, bit 2 blue
    typedef struct packed {
        cmd_op_e                 opcode;
        logic [2:0]              rgb_enable;
        logic [`NUM_PLANES-1:0]  brightness_enable;
        logic [26-`NUM_PLANES:0] pad;
    } config_cmd_t;

    // Opcode lands in the top two bits of either view
    typedef union packed {
        pixel_cmd_t  pix;
        config_cmd_t cfg;
    } cmd_word_u;

endpackage

/* verilog/command_decoder.sv */
`timescale 1ns/1ps
`include "matrix_settings.svh"

module command_decoder
    import matrix_pkg::*;
(
    input  logic                   clk_root,
    input  logic                   rst_n,
    input  logic                   cmd_valid,
    input  cmd_word_u              cmd_word,
    input  logic                   wr_grant,
    output logic                   cmd_ready,
    output logic                   wr_req,
    output fb_addr_t               wr_addr,
    output rgb565_t                wr_data,
    output logic [2:0]             rgb_enable,
    output logic [`NUM_PLANES-1:0] brightness_enable
);
    logic cmd_take;
    logic is_pixel;

    // Host stalls while a pixel write waits for the RAM port
    assign cmd_ready = !wr_req;
    assign cmd_take = cmd_valid && cmd_ready;
    assign is_pixel = (cmd_word.pix.opcode == PIXEL);

    always_ff @(posedge clk_root or negedge rst_n) begin
        if (!rst_n) begin
            wr_req <= 1'b0;
            rgb_enable <= '1;
            brightness_enable <= '1;
        end else begin
            if (wr_req && wr_grant) begin
                wr_req <= 1'b0;              // Written in the grant cycle
            end
            if (cmd_take) begin
                case (cmd_word.pix.opcode)
                    PIXEL: begin
                        wr_req <= 1'b1;
                    end
                    CONFIG: begin
                        rgb_enable <= cmd_word.cfg.rgb_enable;
                        brightness_enable <= cmd_word.cfg.brightness_enable;
                    end
                    default: begin
                        // NOP, accepted and dropped
                    end
                endcase
            end
        end
    end

    // Held until the arbiter grants the write
    always_ff @(posedge clk_root) begin
        if (cmd_take && is_pixel) begin
            wr_addr <= cmd_word.pix.addr;
            wr_data <= cmd_word.pix.pixel;
        end
    end

endmodule

/* framebuffer/fb_arbiter.sv */
`timescale 1ns/1ps

module fb_arbiter
    import matrix_pkg::*;
(
    input  logic     clk_root,
    input  logic     rst_n,
    input  logic     wr_req,
    input  fb_addr_t wr_addr,
    input  rgb565_t  wr_data,
    input  logic     rd_req,
    input  fb_addr_t rd_addr,
    output logic     wr_grant,
    output logic     rd_grant,
    output fb_addr_t mem_addr,
    output logic     mem_we,
    output rgb565_t  mem_wdata
);
    logic last_wr;                       // Writer won the previous grant

    // Lone request wins at once, both alternate
    assign wr_grant = wr_req && (!rd_req || !last_wr);
    assign rd_grant = rd_req && !wr_grant;

    always_ff @(posedge clk_root or negedge rst_n) begin
        if (!rst_n) begin
            last_wr <= 1'b0;
        end else if (wr_grant) begin
            last_wr <= 1'b1;
        end else if (rd_grant) begin
            last_wr <= 1'b0;
        end
    end

    // Winner drives the single RAM port
    assign mem_addr = wr_grant ? wr_addr : rd_addr;
    assign mem_we = wr_grant;
    assign mem_wdata = wr_data;

endmodule

/* framebuffer/fb_memory.sv */
`timescale 1ns/1ps
`include "matrix_settings.svh"

module fb_memory
    import matrix_pkg::*;
(
    input  logic     clk_root,
    input  fb_addr_t mem_addr,
    input  logic     mem_we,
    input  rgb565_t  mem_wdata,
    output rgb565_t  mem_rdata
);
    rgb565_t mem [`FB_DEPTH];

    // Read data follows the address by one cycle
    always_ff @(posedge clk_root) begin
        if (mem_we) begin
            mem[mem_addr] <= mem_wdata;
        end
        mem_rdata <= mem[mem_addr];      // Old word on a write cycle
    end

endmodule

/* verilog/scan_fetch.sv */
`timescale 1ns/1ps
`include "matrix_settings.svh"

module scan_fetch
    import matrix_pkg::*;
(
    input  logic     clk_root,
    input  logic     rst_n,
    input  logic     rd_grant,
    input  rgb565_t  rd_data,
    input  logic     credit_return,
    output logic     rd_req,
    output fb_addr_t rd_addr,
    output logic     pix_valid,
    output rgb565_t  pix_top,
    output rgb565_t  pix_bottom
);
    localparam int COL_W = $clog2(`PANEL_COLS);
    localparam int CRED_W = $clog2(`CREDIT_DEPTH + 1);

    logic [COL_W-1:0]  col;
    row_addr_t         row;
    logic              phase;            // Low for the top read, high for the bottom
    logic              top_land;
    logic              bot_land;
    logic              pair_full;
    rgb565_t           top_buf;
    logic [CRED_W-1:0] credit_cnt;

    assign pix_valid = pair_full && (credit_cnt != '0);

    // No reads once the credits are spent, a held pair always leaves with a credit
    assign rd_req = (credit_cnt != '0);

    // Same walk on every plane, so the address ignores the plane
    assign rd_addr = fb_addr_t'((int'(row) + (phase ? `SCAN_ROWS : 0)) * `PANEL_COLS
                                + int'(col));

    always_ff @(posedge clk_root or negedge rst_n) begin
        if (!rst_n) begin
            col <= '0;
            row <= '0;
            phase <= 1'b0;
            top_land <= 1'b0;
            bot_land <= 1'b0;
            pair_full <= 1'b0;
            credit_cnt <= CRED_W'(`CREDIT_DEPTH);
        end else begin
            top_land <= rd_grant && !phase;
            bot_land <= rd_grant && phase;
            if (rd_grant) begin
                phase <= !phase;
                if (phase) begin
                    if (col == COL_W'(`PANEL_COLS - 1)) begin
                        col <= '0;
                        row <= (row == row_addr_t'(`SCAN_ROWS - 1)) ? '0 : row + 1'b1;
                    end else begin
                        col <= col + 1'b1;
                    end
                end
            end
            if (bot_land) begin
                pair_full <= 1'b1;
            end else if (pix_valid) begin
                pair_full <= 1'b0;
            end
            credit_cnt <= credit_cnt - CRED_W'(pix_valid) + CRED_W'(credit_return);
        end
    end

    // RAM data is valid the cycle after each grant
    always_ff @(posedge clk_root) begin
        if (top_land) begin
            top_buf <= rd_data;
        end
        if (bot_land) begin
            pix_top <= top_buf;
            pix_bottom <= rd_data;
        end
    end

endmodule

/* verilog/panel_shifter.sv */
`timescale 1ns/1ps
`include "matrix_settings.svh"

module panel_shifter
    import matrix_pkg::*;
(
    input  logic                   clk_root,
    input  logic                   rst_n,
    input  logic                   pix_valid,
    input  rgb565_t                pix_top,
    input  rgb565_t                pix_bottom,
    input  logic [2:0]             rgb_enable,
    input  logic [`NUM_PLANES-1:0] brightness_enable,
    output logic                   credit_return,
    output logic                   clk_pixel,
    output logic [2:0]             rgb1,
    output logic [2:0]             rgb2,
    output row_addr_t              row_addr,
    output logic                   row_latch,
    output logic                   output_enable
);
    localparam int COL_W = $clog2(`PANEL_COLS);
    localparam int PLANE_W = $clog2(`NUM_PLANES);
    localparam int PTR_W = $clog2(`CREDIT_DEPTH);
    localparam int CNT_W = $clog2(`CREDIT_DEPTH + 1);
    localparam int OE_W = $clog2(`OE_UNIT << (`NUM_PLANES - 1));

    localparam logic [2:0] ST_FETCH = 3'd0;     // Waiting on the FIFO
    localparam logic [2:0] ST_LOW   = 3'd1;
    localparam logic [2:0] ST_HIGH  = 3'd2;
    localparam logic [2:0] ST_LATCH = 3'd3;
    localparam logic [2:0] ST_OE    = 3'd4;

    rgb565_t            fifo_top [`CREDIT_DEPTH];
    rgb565_t            fifo_bot [`CREDIT_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   fifo_cnt;
    logic [2:0]         state;
    logic [COL_W-1:0]   col_cnt;
    row_addr_t          row_cnt;
    logic [PLANE_W-1:0] plane;
    logic [OE_W-1:0]    oe_cnt;
    logic               last_col;
    logic               pop;

    // Red and blue run one plane behind green, bit 0 is red
    function automatic logic [2:0] slice_bits(input rgb565_t px,
                                              input logic [PLANE_W-1:0] pl,
                                              input logic [2:0] color_en,
                                              input logic plane_en);
        logic red_bit;
        logic green_bit;
        logic blue_bit;
        green_bit = px.green[pl];
        red_bit = (pl == '0) ? 1'b0 : px.red[pl - 1'b1];
        blue_bit = (pl == '0) ? 1'b0 : px.blue[pl - 1'b1];
        return {blue_bit, green_bit, red_bit} & color_en & {3{plane_en}};
    endfunction

    assign last_col = (col_cnt == COL_W'(`PANEL_COLS - 1));
    // Next pixel is loaded while the current one clocks in
    assign pop = (fifo_cnt != '0) &&
                 ((state == ST_FETCH) || (state == ST_HIGH && !last_col) ||
                  (state == ST_OE && oe_cnt == '0));
    assign credit_return = pop;
    assign clk_pixel = (state == ST_HIGH);
    assign row_latch = (state == ST_LATCH);
    assign output_enable = (state == ST_OE);

    always_ff @(posedge clk_root or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fifo_cnt <= '0;
        end else begin
            if (pix_valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(`CREDIT_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(`CREDIT_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            fifo_cnt <= fifo_cnt + CNT_W'(pix_valid) - CNT_W'(pop);
        end
    end

    always_ff @(posedge clk_root) begin
        if (pix_valid) begin
            fifo_top[wr_ptr] <= pix_top;
            fifo_bot[wr_ptr] <= pix_bottom;
        end
        if (pop) begin
            rgb1 <= slice_bits(fifo_top[rd_ptr], plane, rgb_enable, brightness_enable[plane]);
            rgb2 <= slice_bits(fifo_bot[rd_ptr], plane, rgb_enable, brightness_enable[plane]);
        end
    end

    always_ff @(posedge clk_root or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_FETCH;
            col_cnt <= '0;
            row_cnt <= '0;
            plane <= '0;
            oe_cnt <= '0;
            row_addr <= '0;
        end else begin
            case (state)
                ST_FETCH: begin
                    if (pop) begin
                        state <= ST_LOW;
                    end
                end
                ST_LOW: begin
                    state <= ST_HIGH;
                end
                ST_HIGH: begin
                    if (last_col) begin
                        col_cnt <= '0;
                        row_addr <= row_cnt;    // Panel sees the row with the latch
                        state <= ST_LATCH;
                    end else begin
                        col_cnt <= col_cnt + 1'b1;
                        state <= pop ? ST_LOW : ST_FETCH;
                    end
                end
                ST_LATCH: begin
                    // Weight taken from the plane just shifted, counters move on
                    oe_cnt <= OE_W'((`OE_UNIT << plane) - 1);
                    if (row_cnt == row_addr_t'(`SCAN_ROWS - 1)) begin
                        row_cnt <= '0;
                        plane <= (plane == PLANE_W'(`NUM_PLANES - 1)) ? '0 : plane + 1'b1;
                    end else begin
                        row_cnt <= row_cnt + 1'b1;
                    end
                    state <= ST_OE;
                end
                ST_OE: begin
                    if (oe_cnt == '0) begin
                        state <= pop ? ST_LOW : ST_FETCH;
                    end else begin
                        oe_cnt <= oe_cnt - 1'b1;
                    end
                end
                default: begin
                    state <= ST_FETCH;
                end
            endcase
        end
    end

endmodule

/* verilog/led_matrix_top.sv */
`timescale 1ns/1ps
`include "matrix_settings.svh"

module led_matrix_top
    import matrix_pkg::*;
(
    input  logic       clk_root,
    input  logic       rst_n,
    input  logic       cmd_valid,
    input  cmd_word_u  cmd_word,
    output logic       cmd_ready,
    output logic       clk_pixel,
    output logic [2:0] rgb1,
    output logic [2:0] rgb2,
    output row_addr_t  row_addr,
    output logic       row_latch,
    output logic       output_enable
);
    logic                   wr_req;
    logic                   wr_grant;
    fb_addr_t               wr_addr;
    rgb565_t                wr_data;
    logic                   rd_req;
    logic                   rd_grant;
    fb_addr_t               rd_addr;
    fb_addr_t               mem_addr;
    logic                   mem_we;
    rgb565_t                mem_wdata;
    rgb565_t                mem_rdata;
    logic                   pix_valid;
    rgb565_t                pix_top;
    rgb565_t                pix_bottom;
    logic                   credit_return;
    logic [2:0]             rgb_enable;
    logic [`NUM_PLANES-1:0] brightness_enable;

    command_decoder i_command_decoder (
        .clk_root          (clk_root),
        .rst_n             (rst_n),
        .cmd_valid         (cmd_valid),
        .cmd_word          (cmd_word),
        .wr_grant          (wr_grant),
        .cmd_ready         (cmd_ready),
        .wr_req            (wr_req),
        .wr_addr           (wr_addr),
        .wr_data           (wr_data),
        .rgb_enable        (rgb_enable),
        .brightness_enable (brightness_enable)
    );

    // Decoder writes and fetch reads share one RAM port
    fb_arbiter i_fb_arbiter (
        .clk_root  (clk_root),
        .rst_n     (rst_n),
        .wr_req    (wr_req),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .wr_grant  (wr_grant),
        .rd_grant  (rd_grant),
        .mem_addr  (mem_addr),
        .mem_we    (mem_we),
        .mem_wdata (mem_wdata)
    );

    fb_memory i_fb_memory (
        .clk_root  (clk_root),
        .mem_addr  (mem_addr),
        .mem_we    (mem_we),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

    scan_fetch i_scan_fetch (
        .clk_root      (clk_root),
        .rst_n         (rst_n),
        .rd_grant      (rd_grant),
        .rd_data       (mem_rdata),
        .credit_return (credit_return),
        .rd_req        (rd_req),
        .rd_addr       (rd_addr),
        .pix_valid     (pix_valid),
        .pix_top       (pix_top),
        .pix_bottom    (pix_bottom)
    );

    panel_shifter i_panel_shifter (
        .clk_root          (clk_root),
        .rst_n             (rst_n),
        .pix_valid         (pix_valid),
        .pix_top           (pix_top),
        .pix_bottom        (pix_bottom),
        .rgb_enable        (rgb_enable),
        .brightness_enable (brightness_enable),
        .credit_return     (credit_return),
        .clk_pixel         (clk_pixel),
        .rgb1              (rgb1),
        .rgb2              (rgb2),
        .row_addr          (row_addr),
        .row_latch         (row_latch),
        .output_enable     (output_enable)
    );

endmodule

/* test/tb_led_matrix.sv */
`timescale 1ns/1ps
`include "matrix_settings.svh"

module tb_led_matrix
    import matrix_pkg::*;
();
    localparam int ROWS_PER_FRAME = `SCAN_ROWS * `NUM_PLANES;
    localparam int ROW_CYC = 2 * `PANEL_COLS + 1;
    localparam int OE_SUM = `SCAN_ROWS * ((1 << `NUM_PLANES) - 1) * `OE_UNIT;
    localparam int FRAME_CYC = ROWS_PER_FRAME * ROW_CYC + OE_SUM;
    localparam int REC_DEPTH = 1024;

    logic       clk_root;
    logic       rst_n;
    logic       cmd_valid;
    cmd_word_u  cmd_word;
    logic       cmd_ready;
    logic       clk_pixel;
    logic [2:0] rgb1;
    logic [2:0] rgb2;
    row_addr_t  row_addr;
    logic       row_latch;
    logic       output_enable;

    // Parsed pattern file, one entry per line
    byte           op_kind [$];
    logic [31:0]   op_word [$];
    logic [95:0]   op_lanes [$];
    logic [127:0]  op_name [$];

    // Rows seen on the panel, indexed by latch number
    logic [15:0]   cur_lane [6];
    logic [15:0]   rec_lane [REC_DEPTH][6];
    int            rec_pulses [REC_DEPTH];
    row_addr_t     rec_row [REC_DEPTH];
    int            rec_oe [REC_DEPTH];
    int            pulses;
    int            latch_cnt;
    int            oe_run;
    int            oe_done;
    int            ready_low_cnt = 0;

    int            seed = 61;
    int            cycle = 0;
    int            limit = 1000000;
    int            frame_base;
    int            test_err;
    int            err_cnt = 0;
    int            tests_run = 0;
    int            tests_bad = 0;
    int            low_base;
    bit            has_fill;
    bit            in_test;
    logic [127:0]  cur_name;
    string         lane_name [6] = '{"rgb1 red", "rgb1 green", "rgb1 blue",
                                     "rgb2 red", "rgb2 green", "rgb2 blue"};

    led_matrix_top i_led_matrix_top (
        .clk_root      (clk_root),
        .rst_n         (rst_n),
        .cmd_valid     (cmd_valid),
        .cmd_word      (cmd_word),
        .cmd_ready     (cmd_ready),
        .clk_pixel     (clk_pixel),
        .rgb1          (rgb1),
        .rgb2          (rgb2),
        .row_addr      (row_addr),
        .row_latch     (row_latch),
        .output_enable (output_enable)
    );

    initial begin
        clk_root = 1'b0;
        forever #2 clk_root = ~clk_root;
    end

    always @(posedge clk_root) begin
        cycle++;
        if (cycle >= limit) begin
            $display("Timeout after %0d cycles, the panel stopped delivering rows", cycle);
            $display("Verification failed");
            $finish;
        end
    end

    // Panel monitor, bit c of a lane word is column c
    always @(posedge clk_root or negedge rst_n) begin
        if (!rst_n) begin
            pulses = 0;
            latch_cnt = 0;
            oe_run = 0;
            oe_done = 0;
        end else begin
            if (!cmd_ready) ready_low_cnt++;
            if (clk_pixel) begin
                if (pulses < `PANEL_COLS) begin
                    for (int i = 0; i < 3; i++) begin
                        cur_lane[i][pulses[3:0]] = rgb1[i];
                        cur_lane[i + 3][pulses[3:0]] = rgb2[i];
                    end
                end
                pulses++;
            end
            if (row_latch && latch_cnt < REC_DEPTH) begin
                for (int i = 0; i < 6; i++) rec_lane[latch_cnt][i] = cur_lane[i];
                rec_pulses[latch_cnt] = pulses;
                rec_row[latch_cnt] = row_addr;     // Already updated in the latch cycle
                latch_cnt++;
                pulses = 0;
            end
            if (output_enable) begin
                oe_run++;
            end else if (oe_run != 0) begin
                rec_oe[latch_cnt - 1] = oe_run;
                oe_done = latch_cnt;
                oe_run = 0;
            end
        end
    end

    task automatic check_lane(input string name, input logic [15:0] got,
                              input logic [15:0] exp);
        if (got !== exp) begin
            $display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
            test_err++;
        end
    endtask

    task automatic check_row(input string name, input row_addr_t got, input row_addr_t exp);
        if (got !== exp) begin
            $display("ERROR %0t %s got %0d expected %0d", $time, name, got, exp);
            test_err++;
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("ERROR %0t %s got %0d expected %0d", $time, name, got, exp);
            test_err++;
        end
    endtask

    // Address pattern touching every address bit
    function automatic rgb565_t fill_pixel(input fb_addr_t a);
        rgb565_t px;
        px.red = a[4:0];
        px.green = {a[6:4], a[2:0]};
        px.blue = a[6:2];
        return px;
    endfunction

    task automatic send_word(input logic [31:0] w);
        int gap;
        gap = $random(seed) & 3;
        repeat (gap) begin
            @(posedge clk_root);
            #1;
        end
        cmd_word = w;
        cmd_valid = 1'b1;
        do @(posedge clk_root); while (!cmd_ready);
        #1 cmd_valid = 1'b0;
    endtask

    task automatic fill_frame();
        pixel_cmd_t pc;
        for (int a = 0; a < `FB_DEPTH; a++) begin
            pc.opcode = PIXEL;
            pc.pad = '0;
            pc.addr = fb_addr_t'(a);
            pc.pixel = fill_pixel(fb_addr_t'(a));
            send_word(pc);
        end
    endtask

    // Skip rows that may hold pixels fetched before the last command landed
    task automatic pick_frame();
        int seen;
        while (!cmd_ready) @(posedge clk_root);
        seen = latch_cnt;
        frame_base = ((seen + 2 + ROWS_PER_FRAME - 1) / ROWS_PER_FRAME) * ROWS_PER_FRAME;
    endtask

    task automatic check_panel_row(input int plane, input int row, input logic [95:0] lanes);
        int idx;
        idx = frame_base + plane * `SCAN_ROWS + row;
        while (oe_done <= idx) @(posedge clk_root);
        for (int i = 0; i < 6; i++) begin
            check_lane($sformatf("plane %0d row %0d %s", plane, row, lane_name[i]),
                       rec_lane[idx][i], lanes[95 - 16 * i -: 16]);
        end
        check_count($sformatf("plane %0d row %0d clk_pixel pulses", plane, row),
                    rec_pulses[idx], `PANEL_COLS);
        check_row($sformatf("plane %0d row %0d row_addr", plane, row),
                  rec_row[idx], row_addr_t'(row));
        check_count($sformatf("plane %0d row %0d output_enable cycles", plane, row),
                    rec_oe[idx], `OE_UNIT << plane);
    endtask

    task automatic start_test(input logic [127:0] name);
        cur_name = name;
        in_test = 1'b1;
        test_err = 0;
        has_fill = 1'b0;
        low_base = ready_low_cnt;
    endtask

    task automatic end_test();
        if (has_fill && ready_low_cnt == low_base) begin
            $display("cmd_ready never dropped while pixel writes waited in %0s", cur_name);
            test_err++;
        end
        tests_run++;
        if (test_err != 0) tests_bad++;
        $display("[%0t] test %0s done, %0d mismatches", $time, cur_name, test_err);
        err_cnt += test_err;
        in_test = 1'b0;
    endtask

    task automatic read_patterns(output int n_cmd, output int n_groups);
        int fd;
        int c;
        int r;
        int ev [8];
        logic [127:0] nm;
        byte ch;
        byte prev;
        n_cmd = 0;
        n_groups = 0;
        prev = "#";
        fd = $fopen("test/matrix_patterns.txt", "r");
        if (fd == 0) begin
            $display("Cannot open test/matrix_patterns.txt");
            err_cnt++;
        end else begin
            c = $fgetc(fd);
            while (c != -1) begin
                ch = 8'(c);
                case (ch)
                    "#": begin
                        while (c != 10 && c != -1) c = $fgetc(fd);
                    end
                    "T", "C", "F", "E": begin
                        nm = '0;
                        ev = '{default: 0};
                        if (ch == "T") r = $fscanf(fd, " %s", nm);
                        if (ch == "C") r = $fscanf(fd, " %h", ev[0]);
                        if (ch == "E") begin
                            r = $fscanf(fd, " %d %d %h %h %h %h %h %h", ev[0], ev[1],
                                        ev[2], ev[3], ev[4], ev[5], ev[6], ev[7]);
                        end
                        if ((ch == "C" && r != 1) || (ch == "E" && r != 8)) begin
                            $display("Pattern file has an unreadable %c line", ch);
                            err_cnt++;
                        end
                        if (ch == "C") n_cmd += 1;
                        if (ch == "F") n_cmd += `FB_DEPTH;
                        if (ch == "E" && prev != "E") n_groups++;
                        op_kind.push_back(ch);
                        if (ch == "C") begin
                            op_word.push_back(ev[0]);
                        end else begin
                            op_word.push_back({ev[0][15:0], ev[1][15:0]});
                        end
                        op_lanes.push_back({ev[2][15:0], ev[3][15:0], ev[4][15:0],
                                            ev[5][15:0], ev[6][15:0], ev[7][15:0]});
                        op_name.push_back(nm);
                        prev = ch;
                    end
                    default: begin
                    end
                endcase
                c = $fgetc(fd);
            end
            $fclose(fd);
        end
    endtask

    initial begin
        int n_cmd;
        int n_groups;
        rst_n = 1'b0;
        cmd_valid = 1'b0;
        cmd_word = '0;
        read_patterns(n_cmd, n_groups);
        // Each check group may wait out a partial frame, plus slack for fetch stalls
        limit = n_cmd * 8 + (2 * n_groups + 4) * FRAME_CYC;

        repeat (2) @(posedge clk_root);
        #1 rst_n = 1'b1;
        start_test("reset");
        check_count("clk_pixel", int'(clk_pixel), 0);
        check_count("row_latch", int'(row_latch), 0);
        check_count("output_enable", int'(output_enable), 0);
        check_row("row_addr", row_addr, '0);
        check_count("cmd_ready", int'(cmd_ready), 1);
        end_test();

        for (int k = 0; k < op_kind.size(); k++) begin
            case (op_kind[k])
                "T": begin
                    if (in_test) end_test();
                    start_test(op_name[k]);
                end
                "C": begin
                    send_word(op_word[k]);
                end
                "F": begin
                    fill_frame();
                    has_fill = 1'b1;
                end
                default: begin
                    if (k == 0 || op_kind[k - 1] != "E") pick_frame();
                    check_panel_row(int'(op_word[k][31:16]), int'(op_word[k][15:0]),
                                    op_lanes[k]);
                end
            endcase
        end
        if (in_test) end_test();

        $display("Tests %0d, with mismatches %0d, total mismatches %0d",
                 tests_run, tests_bad, err_cnt);
        if (err_cnt == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* test/matrix_patterns.txt */
# T name | C command word | F write all 128 pixels from the address pattern
# E plane row rgb1_red rgb1_green rgb1_blue rgb2_red rgb2_green rgb2_blue
T fill_and_scan
F
E 0 0 0000 AAAA 0000 0000 AAAA 0000
E 0 1 0000 AAAA 0000 0000 AAAA 0000
E 0 2 0000 AAAA 0000 0000 AAAA 0000
E 0 3 0000 AAAA 0000 0000 AAAA 0000
E 1 0 AAAA CCCC F0F0 AAAA CCCC F0F0
E 1 1 AAAA CCCC F0F0 AAAA CCCC F0F0
E 1 2 AAAA CCCC F0F0 AAAA CCCC F0F0
E 1 3 AAAA CCCC F0F0 AAAA CCCC F0F0
E 2 0 CCCC F0F0 FF00 CCCC F0F0 FF00
E 2 1 CCCC F0F0 FF00 CCCC F0F0 FF00
E 2 2 CCCC F0F0 FF00 CCCC F0F0 FF00
E 2 3 CCCC F0F0 FF00 CCCC F0F0 FF00
E 3 0 F0F0 0000 0000 F0F0 0000 0000
E 3 1 F0F0 FFFF FFFF F0F0 FFFF FFFF
E 3 2 F0F0 0000 0000 F0F0 0000 0000
E 3 3 F0F0 FFFF FFFF F0F0 FFFF FFFF
E 4 0 FF00 0000 0000 FF00 0000 0000
E 4 1 FF00 0000 0000 FF00 0000 0000
E 4 2 FF00 FFFF FFFF FF00 FFFF FFFF
E 4 3 FF00 FFFF FFFF FF00 FFFF FFFF
E 5 0 0000 0000 0000 0000 FFFF FFFF
E 5 1 FFFF 0000 0000 FFFF FFFF FFFF
E 5 2 0000 0000 0000 0000 FFFF FFFF
E 5 3 FFFF 0000 0000 FFFF FFFF FFFF
# Green off and plane 2 off, then a NOP
T config_and_nop
C AF600000
C 00000000
E 0 0 0000 0000 0000 0000 0000 0000
E 0 1 0000 0000 0000 0000 0000 0000
E 0 2 0000 0000 0000 0000 0000 0000
E 0 3 0000 0000 0000 0000 0000 0000
E 1 0 AAAA 0000 F0F0 AAAA 0000 F0F0
E 1 1 AAAA 0000 F0F0 AAAA 0000 F0F0
E 1 2 AAAA 0000 F0F0 AAAA 0000 F0F0
E 1 3 AAAA 0000 F0F0 AAAA 0000 F0F0
E 2 0 0000 0000 0000 0000 0000 0000
E 2 1 0000 0000 0000 0000 0000 0000
E 2 2 0000 0000 0000 0000 0000 0000
E 2 3 0000 0000 0000 0000 0000 0000
E 3 0 F0F0 0000 0000 F0F0 0000 0000
E 3 1 F0F0 0000 FFFF F0F0 0000 FFFF
E 3 2 F0F0 0000 0000 F0F0 0000 0000
E 3 3 F0F0 0000 FFFF F0F0 0000 FFFF
E 4 0 FF00 0000 0000 FF00 0000 0000
E 4 1 FF00 0000 0000 FF00 0000 0000
E 4 2 FF00 0000 FFFF FF00 0000 FFFF
E 4 3 FF00 0000 FFFF FF00 0000 FFFF
E 5 0 0000 0000 0000 0000 0000 FFFF
E 5 1 FFFF 0000 0000 FFFF 0000 FFFF
E 5 2 0000 0000 0000 0000 0000 FFFF
E 5 3 FFFF 0000 0000 FFFF 0000 FFFF

/* tb.f */
+incdir+common
common/matrix_pkg.sv
verilog/command_decoder.sv
framebuffer/fb_arbiter.sv
framebuffer/fb_memory.sv
verilog/scan_fetch.sv
verilog/panel_shifter.sv
verilog/led_matrix_top.sv
test/tb_led_matrix.sv

/* run_sim.sh */
#!/bin/sh
# Build and run from the project root
verilator --binary --timing -f tb.f --top-module tb_led_matrix -o sim_led_matrix \
    && ./obj_dir/sim_led_matrix | tee /dev/stderr | grep -q "Verification passed" \
    || { echo "simulation did not pass"; exit 1; }
